/* tb/pmu_cases.txt */
// columns, all hex: op addr_or_signal value max_wait; op 1 write 2 read 3 lpmd 4 intr
// 5 wait-until 6 expect-after-wait 7 read-at-most; signals 0 gate0 1 gate1 2 pwr 3 iso_in 4 iso_out 5 save 6 restore
// registers after reset, readback, reserved bit, unmapped address
2 000 00000000 00
2 004 00000000 00
2 008 00000000 00
1 000 fffffff5 00
2 000 00000005 00
1 004 00000123 00
2 004 00000123 00
1 008 00000001 00
2 008 00000001 00
2 00c 00000000 00
// light sleep with clock slow, interrupt wakeup
1 000 00000001 00
1 008 00000002 00
3 000 00000000 00
5 000 00000001 08
6 001 00000000 00
4 000 00000001 00
5 000 00000000 08
4 000 00000000 00
3 000 00000003 00
1 008 00000004 00
2 008 00000004 00
// light sleep with clock off, mode write refused while asleep
3 000 00000000 00
5 001 00000001 08
6 000 00000000 00
1 008 00000010 00
4 000 00000001 00
5 001 00000000 08
4 000 00000000 00
3 000 00000003 00
2 008 00000004 00
// event timer wakeup, reload 0x10, wake within reload plus 4
1 004 00000010 00
1 000 0000000a 00
7 004 00000010 00
7 004 00000010 00
3 000 00000000 00
5 001 00000001 04
5 001 00000000 14
3 000 00000003 00
1 000 00000001 00
// deep sleep entry with retention
1 008 00000008 00
3 000 00000000 00
5 001 00000001 08
5 003 00000001 20
6 005 00000000 00
6 002 00000001 00
5 005 00000001 20
6 003 00000001 00
6 001 00000001 00
6 005 00000000 01
6 002 00000001 00
5 002 00000000 20
6 001 00000001 00
// deep sleep exit by interrupt
4 000 00000001 00
5 002 00000001 20
6 006 00000000 00
6 003 00000001 00
5 006 00000001 08
6 002 00000001 00
6 003 00000001 00
6 006 00000000 01
6 003 00000001 00
5 003 00000000 10
6 004 00000000 00
4 000 00000000 00
3 000 00000003 00
6 001 00000000 0c
1 008 00000001 00
2 008 00000001 00

/* filelist.f */
hdl/pmu_pkg.sv
hdl/pmu_apb_regs.sv
hdl/pmu_event_timer.sv
hdl/pmu_wake_ctrl.sv
hdl/pmu_mode_fsm.sv
hdl/pmu_pwr_seq.sv
hdl/pmu_top.sv
tb/pmu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the pmu testbench with verilator, run it and report pass or fail

set -u

cd "$(dirname "$0")" || exit 1

build_dir="obj_dir"
sim_bin="pmu_sim"

# compile and elaborate
if ! verilator --binary --timing -f filelist.f --top-module pmu_tb \
    -Mdir "$build_dir" -o "$sim_bin"; then
  echo "verilator build failed"
  exit 1
fi

# run the simulation and keep its output for the verdict
if ! sim_out=$("./$build_dir/$sim_bin"); then
  echo "$sim_out"
  echo "simulation exited with an error status"
  exit 1
fi
echo "$sim_out"

if echo "$sim_out" | grep -qx "Test completed successfully"; then
  exit 0
fi

echo "pass message not found in simulation output"
exit 1

/* tb/pmu_tb.sv */
// pmu testbench: replays the cases file over apb and the sleep inputs and checks pmu outputs
`timescale 1ns/100ps

module pmu_tb;

  localparam int MAX_STEPS = 128;
  localparam int SEQ_STEP  = 4;

  // step opcodes, see the cases file
  localparam logic [3:0] OP_END    = 4'h0;
  localparam logic [3:0] OP_WRITE  = 4'h1;
  localparam logic [3:0] OP_READ   = 4'h2;
  localparam logic [3:0] OP_LPMD   = 4'h3;
  localparam logic [3:0] OP_INTR   = 4'h4;
  localparam logic [3:0] OP_WAIT   = 4'h5;
  localparam logic [3:0] OP_EXPECT = 4'h6;
  localparam logic [3:0] OP_BOUND  = 4'h7;

  logic               pmu_clk;
  logic               pad_cpu_rst_b;
  logic               psel;
  logic               penable;
  logic               pwrite;
  pmu_pkg::apb_addr_t paddr;
  pmu_pkg::apb_data_t pwdata;
  pmu_pkg::apb_data_t prdata;
  logic [1:0]         lpmd_b;
  logic               intraw_vld;
  logic               gate_en0;
  logic               gate_en1;
  logic               cpu_pwr_on;
  logic               cpu_iso_in;
  logic               cpu_iso_out;
  logic               cpu_save;
  logic               cpu_restore;

  // four words per step: op, address or signal code, value, max wait
  logic [31:0] case_mem [0:4*MAX_STEPS-1];
  int          value_errors;
  int          other_errors;
  int          cycle_limit;
  int          cycle_cnt;

  pmu_top #(.CNT_W(32), .SEQ_STEP(SEQ_STEP)) dut_i (
    .i_pmu_clk     (pmu_clk),
    .pad_cpu_rst_b (pad_cpu_rst_b),
    .i_psel        (psel),
    .i_penable     (penable),
    .i_pwrite      (pwrite),
    .i_paddr       (paddr),
    .i_pwdata      (pwdata),
    .o_prdata      (prdata),
    .i_lpmd_b      (lpmd_b),
    .i_intraw_vld  (intraw_vld),
    .o_gate_en0    (gate_en0),
    .o_gate_en1    (gate_en1),
    .o_cpu_pwr_on  (cpu_pwr_on),
    .o_cpu_iso_in  (cpu_iso_in),
    .o_cpu_iso_out (cpu_iso_out),
    .o_cpu_save    (cpu_save),
    .o_cpu_restore (cpu_restore)
  );

  initial
  begin
    pmu_clk = 1'b0;
    forever #10 pmu_clk = ~pmu_clk;
  end

  // ------------------------------
  // signal lookup and checks
  // ------------------------------
  function automatic logic sig_value(input logic [11:0] code);
    case (code)
      12'h000: sig_value = gate_en0;
      12'h001: sig_value = gate_en1;
      12'h002: sig_value = cpu_pwr_on;
      12'h003: sig_value = cpu_iso_in;
      12'h004: sig_value = cpu_iso_out;
      12'h005: sig_value = cpu_save;
      12'h006: sig_value = cpu_restore;
      default: sig_value = 1'bx;
    endcase
  endfunction

  function automatic string sig_name(input logic [11:0] code);
    case (code)
      12'h000: sig_name = "o_gate_en0";
      12'h001: sig_name = "o_gate_en1";
      12'h002: sig_name = "o_cpu_pwr_on";
      12'h003: sig_name = "o_cpu_iso_in";
      12'h004: sig_name = "o_cpu_iso_out";
      12'h005: sig_name = "o_cpu_save";
      12'h006: sig_name = "o_cpu_restore";
      default: sig_name = "unknown signal";
    endcase
  endfunction

  task automatic check_data(input string name, input pmu_pkg::apb_data_t exp,
                            input pmu_pkg::apb_data_t act);
    if (act !== exp)
    begin
      $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_bound(input string name, input pmu_pkg::apb_data_t limit,
                             input pmu_pkg::apb_data_t act);
    if ($isunknown(act) || act > limit)
    begin
      $display("Fail at %0t: %s expected at most %h, got %h", $time, name, limit, act);
      value_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("Fail at %0t: %s expected %b, got %b", $time, name, exp, act);
      value_errors++;
    end
  endtask

  // ------------------------------
  // bus and pin drivers
  // ------------------------------
  // every driver returns on a falling edge, where outputs are settled
  task automatic apb_write(input pmu_pkg::apb_addr_t addr, input pmu_pkg::apb_data_t data);
    @(posedge pmu_clk);
    psel   <= 1'b1;
    pwrite <= 1'b1;
    paddr  <= addr;
    pwdata <= data;
    @(posedge pmu_clk);
    penable <= 1'b1;
    @(posedge pmu_clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    @(negedge pmu_clk);
  endtask

  task automatic apb_read(input pmu_pkg::apb_addr_t addr, output pmu_pkg::apb_data_t data);
    @(posedge pmu_clk);
    psel   <= 1'b1;
    pwrite <= 1'b0;
    paddr  <= addr;
    @(posedge pmu_clk);
    penable <= 1'b1;
    @(negedge pmu_clk);
    data = prdata;
    @(posedge pmu_clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    @(negedge pmu_clk);
  endtask

  task automatic drive_lpmd(input logic [1:0] level);
    @(posedge pmu_clk);
    lpmd_b <= level;
    @(negedge pmu_clk);
  endtask

  task automatic drive_intr(input logic level);
    @(posedge pmu_clk);
    intraw_vld <= level;
    @(negedge pmu_clk);
  endtask

  task automatic wait_level(input logic [11:0] code, input logic level, input int max_cycles);
    int waited;
    waited = 0;
    while (sig_value(code) !== level && waited < max_cycles)
    begin
      @(negedge pmu_clk);
      waited++;
    end
    if (sig_value(code) !== level)
    begin
      $display("%s did not reach %b within %0d cycles, gave up at %0t",
               sig_name(code), level, max_cycles, $time);
      other_errors++;
    end
  endtask

  // run limit, armed once the cases are loaded
  always @(posedge pmu_clk)
  begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit)
    begin
      $display("run stopped after %0d cycles, the limit for these cases", cycle_cnt);
      $display("Test failed");
      $finish;
    end
  end

  // ------------------------------
  // main sequence
  // ------------------------------
  initial
  begin
    int                 step;
    logic [3:0]         op;
    logic [11:0]        code;
    logic [31:0]        value;
    int                 max_wait;
    pmu_pkg::apb_data_t rd_data;

    value_errors = 0;
    other_errors = 0;
    cycle_cnt    = 0;
    cycle_limit  = 100;
    for (step = 0; step < 4 * MAX_STEPS; step++)
      case_mem[step] = '0;
    $readmemh("tb/pmu_cases.txt", case_mem);
    for (step = 0; step < MAX_STEPS; step++)
      cycle_limit += int'(case_mem[4*step+3]);

    pad_cpu_rst_b <= 1'b0;
    psel          <= 1'b0;
    penable       <= 1'b0;
    pwrite        <= 1'b0;
    paddr         <= '0;
    pwdata        <= '0;
    lpmd_b        <= pmu_pkg::LPMD_RUN;
    intraw_vld    <= 1'b0;
    repeat (3) @(posedge pmu_clk);
    pad_cpu_rst_b <= 1'b1;
    @(negedge pmu_clk);

    if (case_mem[0][3:0] == OP_END)
    begin
      $display("no steps were read from the cases file");
      other_errors++;
    end

    step = 0;
    while (step < MAX_STEPS && case_mem[4*step][3:0] != OP_END)
    begin
      op       = case_mem[4*step][3:0];
      code     = case_mem[4*step+1][11:0];
      value    = case_mem[4*step+2];
      max_wait = int'(case_mem[4*step+3]);
      case (op)
        OP_WRITE:
          apb_write(code, value);
        OP_READ:
        begin
          apb_read(code, rd_data);
          check_data($sformatf("o_prdata at %h", code), value, rd_data);
        end
        OP_BOUND:
        begin
          apb_read(code, rd_data);
          check_bound($sformatf("o_prdata at %h", code), value, rd_data);
        end
        OP_LPMD:
          drive_lpmd(value[1:0]);
        OP_INTR:
          drive_intr(value[0]);
        OP_WAIT:
          wait_level(code, value[0], max_wait);
        OP_EXPECT:
        begin
          repeat (max_wait) @(negedge pmu_clk);
          check_flag(sig_name(code), value[0], sig_value(code));
        end
        default:
        begin
          $display("step %0d has an unknown operation %h", step, op);
          other_errors++;
        end
      endcase
      step++;
    end

    $display("run finished: %0d value errors, %0d wait or step errors",
             value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

/* hdl/pmu_top.sv */
// pmu top level: apb registers, event timer, wakeup logic, mode fsm and power sequencer
`timescale 1ns/100ps

module pmu_top #(
  parameter int CNT_W    = 32,
  parameter int SEQ_STEP = 32
) (
  input  logic               i_pmu_clk,
  input  logic               pad_cpu_rst_b,
  input  logic               i_psel,
  input  logic               i_penable,
  input  logic               i_pwrite,
  input  pmu_pkg::apb_addr_t i_paddr,
  input  pmu_pkg::apb_data_t i_pwdata,
  output pmu_pkg::apb_data_t o_prdata,
  input  logic [1:0]         i_lpmd_b,
  input  logic               i_intraw_vld,
  output logic               o_gate_en0,
  output logic               o_gate_en1,
  output logic               o_cpu_pwr_on,
  output logic               o_cpu_iso_in,
  output logic               o_cpu_iso_out,
  output logic               o_cpu_save,
  output logic               o_cpu_restore
);

  logic                         wic_en;
  logic                         event_en;
  logic                         cnt_en;
  logic [CNT_W-1:0]             cnt_load;
  logic [CNT_W-1:0]             cnt_value;
  logic [pmu_pkg::LP_PWR_OFF:0] lp_mode;
  logic                         fsm_normal;
  logic                         timer_event;
  logic                         wakeup;
  pmu_pkg::pmu_state_t          state;
  logic                         in_req;
  logic                         out_req;
  logic                         in_done;
  logic                         out_done;

  // ------------------------------
  // register and timer path
  // ------------------------------
  pmu_apb_regs #(.CNT_W(CNT_W)) u_regs (
    .i_pmu_clk     (i_pmu_clk),
    .pad_cpu_rst_b (pad_cpu_rst_b),
    .i_psel        (i_psel),
    .i_penable     (i_penable),
    .i_pwrite      (i_pwrite),
    .i_paddr       (i_paddr),
    .i_pwdata      (i_pwdata),
    .i_fsm_normal  (fsm_normal),
    .i_cnt_value   (cnt_value),
    .o_prdata      (o_prdata),
    .o_wic_en      (wic_en),
    .o_event_en    (event_en),
    .o_cnt_en      (cnt_en),
    .o_cnt_load    (cnt_load),
    .o_lp_mode     (lp_mode)
  );

  pmu_event_timer #(.CNT_W(CNT_W)) u_timer (
    .i_pmu_clk     (i_pmu_clk),
    .pad_cpu_rst_b (pad_cpu_rst_b),
    .i_cnt_en      (cnt_en),
    .i_cnt_load    (cnt_load),
    .o_cnt_value   (cnt_value),
    .o_event       (timer_event)
  );

  pmu_wake_ctrl u_wake (
    .i_pmu_clk     (i_pmu_clk),
    .pad_cpu_rst_b (pad_cpu_rst_b),
    .i_lpmd_b      (i_lpmd_b),
    .i_intraw_vld  (i_intraw_vld),
    .i_event       (timer_event),
    .i_wic_en      (wic_en),
    .i_event_en    (event_en),
    .o_wakeup      (wakeup)
  );

  // mode control and deep-sleep sequencing
  pmu_mode_fsm u_fsm (
    .i_pmu_clk     (i_pmu_clk),
    .pad_cpu_rst_b (pad_cpu_rst_b),
    .i_lpmd_b      (i_lpmd_b),
    .i_lp_mode     (lp_mode),
    .i_wakeup      (wakeup),
    .i_in_done     (in_done),
    .i_out_done    (out_done),
    .o_state       (state),
    .o_fsm_normal  (fsm_normal),
    .o_gate_en0    (o_gate_en0),
    .o_gate_en1    (o_gate_en1),
    .o_in_req      (in_req),
    .o_out_req     (out_req)
  );

  pmu_pwr_seq #(.SEQ_STEP(SEQ_STEP)) u_seq (
    .i_pmu_clk     (i_pmu_clk),
    .pad_cpu_rst_b (pad_cpu_rst_b),
    .i_state       (state),
    .i_in_req      (in_req),
    .i_out_req     (out_req),
    .o_cpu_pwr_on  (o_cpu_pwr_on),
    .o_cpu_iso_in  (o_cpu_iso_in),
    .o_cpu_iso_out (o_cpu_iso_out),
    .o_cpu_save    (o_cpu_save),
    .o_cpu_restore (o_cpu_restore),
    .o_in_done     (in_done),
    .o_out_done    (out_done)
  );

endmodule

/* hdl/pmu_pwr_seq.sv */
// pmu deep-sleep power sequencer for isolation, save, power and restore
`timescale 1ns/100ps

module pmu_pwr_seq #(
  parameter int SEQ_STEP = 32
) (
  input  logic                i_pmu_clk,
  input  logic                pad_cpu_rst_b,
  input  pmu_pkg::pmu_state_t i_state,
  input  logic                i_in_req,
  input  logic                i_out_req,
  output logic                o_cpu_pwr_on,
  output logic                o_cpu_iso_in,
  output logic                o_cpu_iso_out,
  output logic                o_cpu_save,
  output logic                o_cpu_restore,
  output logic                o_in_done,
  output logic                o_out_done
);

  // counter runs one past the last step before it stops
  localparam int STEP_W = $clog2(3 * SEQ_STEP + 2);

  localparam logic [STEP_W-1:0] STEP_ONE     = STEP_W'(SEQ_STEP);
  localparam logic [STEP_W-1:0] STEP_RESTORE = STEP_W'(SEQ_STEP + 1);
  localparam logic [STEP_W-1:0] STEP_TWO     = STEP_W'(2 * SEQ_STEP);
  localparam logic [STEP_W-1:0] STEP_THREE   = STEP_W'(3 * SEQ_STEP);

  logic              step_en;
  logic [STEP_W-1:0] step_cnt;

  // ------------------------------
  // step counter
  // ------------------------------
  always_ff @(posedge i_pmu_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
      step_en <= 1'b0;
    else if (i_in_req || i_out_req)
      step_en <= 1'b1;
    else if (o_in_done || o_out_done)
      step_en <= 1'b0;
  end

  always_ff @(posedge i_pmu_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
      step_cnt <= '0;
    else if (step_en)
      step_cnt <= step_cnt + 1'b1;
    else
      step_cnt <= '0;
  end

  // ------------------------------
  // power control outputs
  // ------------------------------
  always_ff @(posedge i_pmu_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
    begin
      o_cpu_pwr_on  <= 1'b1;
      o_cpu_iso_in  <= 1'b0;
      o_cpu_iso_out <= 1'b0;
      o_cpu_save    <= 1'b0;
      o_cpu_restore <= 1'b0;
      o_in_done     <= 1'b0;
      o_out_done    <= 1'b0;
    end
    else if (i_state == pmu_pkg::DEEP_SLP)
    begin
      // entry: isolate, save state, then cut power
      o_cpu_restore <= 1'b0;
      o_out_done    <= 1'b0;
      o_cpu_save    <= (step_cnt == STEP_TWO);
      if (step_cnt == STEP_ONE)
      begin
        o_cpu_iso_in  <= 1'b1;
        o_cpu_iso_out <= 1'b1;
      end
      else if (step_cnt == STEP_THREE)
      begin
        o_cpu_pwr_on <= 1'b0;
        o_in_done    <= 1'b1;
      end
    end
    else if (i_state == pmu_pkg::DSLP_TO_NORMAL)
    begin
      // exit: power up, restore, then release isolation
      o_cpu_save    <= 1'b0;
      o_in_done     <= 1'b0;
      o_cpu_restore <= (step_cnt == STEP_RESTORE);
      if (step_cnt == STEP_ONE)
        o_cpu_pwr_on <= 1'b1;
      else if (step_cnt == STEP_TWO)
      begin
        o_cpu_iso_in  <= 1'b0;
        o_cpu_iso_out <= 1'b0;
      end
      else if (step_cnt == STEP_THREE)
        o_out_done <= 1'b1;
    end
  end

endmodule

/* hdl/pmu_mode_fsm.sv */
// pmu mode fsm: normal, light sleep and deep sleep with clock gate control
`timescale 1ns/100ps

module pmu_mode_fsm (
  input  logic                         i_pmu_clk,
  input  logic                         pad_cpu_rst_b,
  input  logic [1:0]                   i_lpmd_b,
  input  logic [pmu_pkg::LP_PWR_OFF:0] i_lp_mode,
  input  logic                         i_wakeup,
  input  logic                         i_in_done,
  input  logic                         i_out_done,
  output pmu_pkg::pmu_state_t          o_state,
  output logic                         o_fsm_normal,
  output logic                         o_gate_en0,
  output logic                         o_gate_en1,
  output logic                         o_in_req,
  output logic                         o_out_req
);

  pmu_pkg::pmu_state_t state_q;
  pmu_pkg::pmu_state_t state_d;
  logic                run_req;
  logic                light_sel;
  logic                deep_sel;

  assign run_req   = (i_lpmd_b == pmu_pkg::LPMD_RUN);
  assign light_sel = i_lp_mode[pmu_pkg::LP_CLK_SLOW] || i_lp_mode[pmu_pkg::LP_CLK_OFF];
  assign deep_sel  = i_lp_mode[pmu_pkg::LP_RET_OFF] || i_lp_mode[pmu_pkg::LP_PWR_OFF];

  always_ff @(posedge i_pmu_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
      state_q <= pmu_pkg::NORMAL;
    else
      state_q <= state_d;
  end

  // ------------------------------
  // next state
  // ------------------------------
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      pmu_pkg::NORMAL:
      begin
        // normal bit wins, then light, then deep
        if (i_lp_mode[pmu_pkg::LP_NORMAL])
          state_d = pmu_pkg::NORMAL;
        else if (light_sel && !run_req)
          state_d = pmu_pkg::LIGHT_SLP;
        else if (deep_sel && !run_req)
          state_d = pmu_pkg::DEEP_SLP;
      end
      pmu_pkg::LIGHT_SLP:
        if (i_wakeup)
          state_d = pmu_pkg::LSLP_TO_NORMAL;
      pmu_pkg::LSLP_TO_NORMAL:
        if (run_req)
          state_d = pmu_pkg::NORMAL;
      pmu_pkg::DEEP_SLP:
        // wakeup waits for the entry sequence to finish
        if (i_wakeup && i_in_done)
          state_d = pmu_pkg::DSLP_TO_NORMAL;
      pmu_pkg::DSLP_TO_NORMAL:
        if (run_req && i_out_done)
          state_d = pmu_pkg::NORMAL;
      default:
        state_d = pmu_pkg::NORMAL;
    endcase
  end

  // sequencer kick pulses
  always_ff @(posedge i_pmu_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
    begin
      o_in_req  <= 1'b0;
      o_out_req <= 1'b0;
    end
    else
    begin
      o_in_req  <= (state_q == pmu_pkg::NORMAL) && (state_d == pmu_pkg::DEEP_SLP);
      o_out_req <= (state_q == pmu_pkg::DEEP_SLP) && (state_d == pmu_pkg::DSLP_TO_NORMAL);
    end
  end

  // gate_en0 slows the clock, gate_en1 stops it
  assign o_gate_en0 = (state_q == pmu_pkg::LIGHT_SLP) && i_lp_mode[pmu_pkg::LP_CLK_SLOW];
  assign o_gate_en1 = ((state_q == pmu_pkg::LIGHT_SLP) && i_lp_mode[pmu_pkg::LP_CLK_OFF]) ||
                      ((state_q == pmu_pkg::DEEP_SLP) && i_lp_mode[pmu_pkg::LP_RET_OFF]);

  assign o_state      = state_q;
  assign o_fsm_normal = (state_q == pmu_pkg::NORMAL);

endmodule

/* hdl/pmu_wake_ctrl.sv */
// pmu wakeup qualification from the interrupt line and timer events
`timescale 1ns/100ps

module pmu_wake_ctrl (
  input  logic       i_pmu_clk,
  input  logic       pad_cpu_rst_b,
  input  logic [1:0] i_lpmd_b,
  input  logic       i_intraw_vld,
  input  logic       i_event,
  input  logic       i_wic_en,
  input  logic       i_event_en,
  output logic       o_wakeup
);

  logic sleep_req;
  logic evt_pending;
  logic evt_wakeup;
  logic wic_wakeup;

  assign sleep_req = (i_lpmd_b != pmu_pkg::LPMD_RUN);

  // ------------------------------
  // pending event latch
  // ------------------------------
  always_ff @(posedge i_pmu_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
      evt_pending <= 1'b0;
    else if (i_event && sleep_req)
      evt_pending <= 1'b1;
    else if (!sleep_req)
      evt_pending <= 1'b0;
  end

  assign evt_wakeup = evt_pending && i_event_en;

  // interrupt only matters while sleep is requested
  assign wic_wakeup = i_intraw_vld && i_wic_en && sleep_req;

  assign o_wakeup = evt_wakeup || wic_wakeup;

endmodule

/* hdl/pmu_event_timer.sv */
// pmu event timer: reloading down-counter with a one-cycle event at zero
`timescale 1ns/100ps

module pmu_event_timer #(
  parameter int CNT_W = 32
) (
  input  logic             i_pmu_clk,
  input  logic             pad_cpu_rst_b,
  input  logic             i_cnt_en,
  input  logic [CNT_W-1:0] i_cnt_load,
  output logic [CNT_W-1:0] o_cnt_value,
  output logic             o_event
);

  logic cnt_en_q;
  logic load_en;
  logic evt_cond;
  logic evt_q;

  // reload on enable rising edge and on every zero
  assign load_en  = (i_cnt_en && !cnt_en_q) || (o_cnt_value == '0);
  assign evt_cond = (o_cnt_value == '0) && i_cnt_en;

  always_ff @(posedge i_pmu_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
    begin
      cnt_en_q    <= 1'b0;
      evt_q       <= 1'b0;
      o_cnt_value <= '0;
    end
    else
    begin
      cnt_en_q <= i_cnt_en;
      evt_q    <= evt_cond;
      if (load_en)
        o_cnt_value <= i_cnt_load;
      else if (i_cnt_en)
        o_cnt_value <= o_cnt_value - 1'b1;
    end
  end

  // first cycle of the zero condition only
  assign o_event = evt_cond && !evt_q;

endmodule

/* hdl/pmu_apb_regs.sv */
// pmu apb register block: control, timer reload and low-power mode registers
`timescale 1ns/100ps

module pmu_apb_regs #(
  parameter int CNT_W = 32
) (
  input  logic                             i_pmu_clk,
  input  logic                             pad_cpu_rst_b,
  input  logic                             i_psel,
  input  logic                             i_penable,
  input  logic                             i_pwrite,
  input  pmu_pkg::apb_addr_t               i_paddr,
  input  pmu_pkg::apb_data_t               i_pwdata,
  input  logic                             i_fsm_normal,
  input  logic [CNT_W-1:0]                 i_cnt_value,
  output pmu_pkg::apb_data_t               o_prdata,
  output logic                             o_wic_en,
  output logic                             o_event_en,
  output logic                             o_cnt_en,
  output logic [CNT_W-1:0]                 o_cnt_load,
  output logic [pmu_pkg::LP_PWR_OFF:0]     o_lp_mode
);

  logic [pmu_pkg::CTRL_RD_W-1:0] ctrl_q;
  logic                          wr_en;

  // access phase of a write transfer
  assign wr_en = i_psel && i_penable && i_pwrite;

  // ------------------------------
  // write decode
  // ------------------------------
  always_ff @(posedge i_pmu_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
    begin
      ctrl_q     <= '0;
      o_cnt_load <= '0;
      o_lp_mode  <= '0;
    end
    else if (wr_en)
    begin
      case (i_paddr)
        pmu_pkg::ADDR_CTRL:     ctrl_q     <= i_pwdata[pmu_pkg::CTRL_RD_W-1:0];
        pmu_pkg::ADDR_CNT_LOAD: o_cnt_load <= i_pwdata[CNT_W-1:0];
        pmu_pkg::ADDR_LP_MODE:
        begin
          // mode only changes while the cpu is fully awake
          if (i_fsm_normal)
            o_lp_mode <= i_pwdata[pmu_pkg::LP_PWR_OFF:0];
        end
        default: ;
      endcase
    end
  end

  // ------------------------------
  // read mux
  // ------------------------------
  always_comb
  begin
    o_prdata = '0;
    if (i_psel && !i_pwrite)
    begin
      case (i_paddr)
        pmu_pkg::ADDR_CTRL:     o_prdata = pmu_pkg::apb_data_t'(ctrl_q);
        // live count, not the reload value
        pmu_pkg::ADDR_CNT_LOAD: o_prdata = pmu_pkg::apb_data_t'(i_cnt_value);
        pmu_pkg::ADDR_LP_MODE:  o_prdata = pmu_pkg::apb_data_t'(o_lp_mode);
        default:                o_prdata = '0;
      endcase
    end
  end

  assign o_wic_en   = ctrl_q[pmu_pkg::CTRL_WIC_EN];
  assign o_event_en = ctrl_q[pmu_pkg::CTRL_EVENT_EN];
  assign o_cnt_en   = ctrl_q[pmu_pkg::CTRL_CNT_EN];

endmodule

/* hdl/pmu_pkg.sv */
// pmu shared definitions: bus widths, register map, bit positions and fsm states
package pmu_pkg;

  // ------------------------------
  // apb bus types
  // ------------------------------
  typedef logic [11:0] apb_addr_t;
  typedef logic [31:0] apb_data_t;

  // register offsets
  localparam apb_addr_t ADDR_CTRL     = 12'h000;
  localparam apb_addr_t ADDR_CNT_LOAD = 12'h004;
  localparam apb_addr_t ADDR_LP_MODE  = 12'h008;

  // control register bits, bit 2 is reserved but stored
  localparam int CTRL_WIC_EN   = 0;
  localparam int CTRL_EVENT_EN = 1;
  localparam int CTRL_CNT_EN   = 3;
  localparam int CTRL_RD_W     = 4;

  // ------------------------------
  // low-power mode register bits
  // ------------------------------
  localparam int LP_NORMAL   = 0;
  localparam int LP_CLK_SLOW = 1;
  localparam int LP_CLK_OFF  = 2;
  localparam int LP_RET_OFF  = 3;
  localparam int LP_PWR_OFF  = 4;

  // cpu running, anything else asks for sleep
  localparam logic [1:0] LPMD_RUN = 2'b11;

  typedef enum logic [2:0] {
    NORMAL         = 3'd0,
    LIGHT_SLP      = 3'd1,
    LSLP_TO_NORMAL = 3'd2,
    DEEP_SLP       = 3'd3,
    DSLP_TO_NORMAL = 3'd4
  } pmu_state_t;

endpackage
